// ==== include/mmu_consts.svh ====
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// tlb geometry
`define MMU_TLBNUM          16
`define MMU_IDX_W           4

// index register
`define MMU_PROBE_FAIL_BIT  31

// entryhi fields
`define MMU_HI_VPN2_MSB     31
`define MMU_HI_VPN2_LSB     13
`define MMU_HI_ASID_MSB     7
`define MMU_HI_ASID_LSB     0
`define MMU_ENTRYHI_MASK    32'hffff_e0ff

// entrylo fields
`define MMU_LO_PFN_MSB      25
`define MMU_LO_PFN_LSB      6
`define MMU_LO_C_MSB        5
`define MMU_LO_C_LSB        3
`define MMU_LO_D_BIT        2
`define MMU_LO_V_BIT        1
`define MMU_LO_G_BIT        0
`define MMU_ENTRYLO_MASK    32'h03ff_ffff

// page offset inside one half of an entry pair
`define MMU_PAGE_OFS_W      12
`define MMU_ODD_PAGE_BIT    12

`endif

// ==== logic/mmu_op_pkg.sv ====
package mmu_op_pkg;

    // decoded operation
    typedef enum logic [3:0] {
        OP_MTC0  = 4'd0,
        OP_MFC0  = 4'd1,
        OP_TLBP  = 4'd2,
        OP_TLBR  = 4'd3,
        OP_TLBWI = 4'd4,
        OP_XLATE = 4'd5,
        OP_NOP   = 4'd15
    } mmu_op_e;

    // cp0 register select for mtc0/mfc0
    typedef enum logic [1:0] {
        SEL_INDEX    = 2'd0,
        SEL_ENTRYHI  = 2'd1,
        SEL_ENTRYLO0 = 2'd2,
        SEL_ENTRYLO1 = 2'd3
    } cp0_sel_e;

endpackage

// ==== logic/tlb_pkg.sv ====
package tlb_pkg;

    // one page half of an entry pair
    typedef struct packed {
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
    } tlb_lo_t;

    // stored tlb entry, lo0 is the even page
    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;
        tlb_lo_t     lo0;
        tlb_lo_t     lo1;
    } tlb_entry_t;

endpackage

// ==== logic/mmu_cmd_decode.sv ====
`timescale 1ns/1ps

module mmu_cmd_decode
    import mmu_op_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        cmd_valid,
    input  logic [3:0]  cmd_op,
    input  logic [1:0]  cmd_sel,
    input  logic [31:0] cmd_data,
    output logic        dec_valid,
    output mmu_op_e     dec_op,
    output cp0_sel_e    dec_sel,
    output logic [31:0] dec_data,
    output logic        dec_illegal
);

    mmu_op_e op_next;
    logic    illegal_next;

    always_comb begin
        illegal_next = 1'b0;
        case (cmd_op)
            4'd0: op_next = OP_MTC0;
            4'd1: op_next = OP_MFC0;
            4'd2: op_next = OP_TLBP;
            4'd3: op_next = OP_TLBR;
            4'd4: op_next = OP_TLBWI;
            4'd5: op_next = OP_XLATE;
            default: begin
                // unknown code becomes a bubble with a flag
                op_next      = OP_NOP;
                illegal_next = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= cmd_valid;
        end
    end

    always_ff @(posedge clk) begin
        dec_op      <= op_next;
        dec_sel     <= cp0_sel_e'(cmd_sel);
        dec_data    <= cmd_data;
        dec_illegal <= illegal_next;
    end

    // raw codes above xlate turn into a flagged nop one edge later
    a_illegal_nop: assert property (@(posedge clk) disable iff (reset)
        cmd_valid && (cmd_op > 4'd5) |=> dec_valid && dec_illegal && (dec_op == OP_NOP));

endmodule

// ==== logic/mmu_cmd_execute.sv ====
`timescale 1ns/1ps
`include "mmu_consts.svh"

module mmu_cmd_execute
    import mmu_op_pkg::*;
    import tlb_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  dec_valid,
    input  mmu_op_e               dec_op,
    input  cp0_sel_e              dec_sel,
    input  logic [31:0]           dec_data,
    input  logic                  dec_illegal,
    input  logic [31:0]           cp0_index,
    input  logic [31:0]           cp0_entryhi,
    input  logic [31:0]           cp0_entrylo0,
    input  logic [31:0]           cp0_entrylo1,
    input  logic                  s0_found,
    input  logic [19:0]           s0_pfn,
    input  logic                  s0_v,
    input  logic                  s1_found,
    input  logic [`MMU_IDX_W-1:0] s1_index,
    input  tlb_entry_t            r_entry,
    output logic [31:0]           s0_vaddr,
    output logic                  exe_valid,
    output mmu_op_e               exe_op,
    output cp0_sel_e              exe_sel,
    output logic [31:0]           exe_data,
    output logic                  exe_miss,
    output logic                  exe_illegal,
    output logic [31:0]           exe_probe_index,
    output tlb_entry_t            exe_r_entry
);

    logic [31:0] ex_data;
    logic [31:0] rd_value;
    logic        xlate_hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        exe_op      <= dec_op;
        exe_sel     <= dec_sel;
        ex_data     <= dec_data;
        exe_illegal <= dec_illegal;
    end

    // xlate searches with the held virtual address
    assign s0_vaddr = ex_data;

    always_comb begin
        case (exe_sel)
            SEL_INDEX:    rd_value = cp0_index;
            SEL_ENTRYHI:  rd_value = cp0_entryhi;
            SEL_ENTRYLO0: rd_value = cp0_entrylo0;
            default:      rd_value = cp0_entrylo1;
        endcase
    end

    assign xlate_hit = s0_found && s0_v;

    always_comb begin
        case (exe_op)
            OP_MTC0:  exe_data = ex_data;
            OP_MFC0:  exe_data = rd_value;
            OP_XLATE: exe_data = xlate_hit ? {s0_pfn, ex_data[`MMU_PAGE_OFS_W-1:0]} : 32'd0;
            default:  exe_data = 32'd0;
        endcase
    end

    assign exe_miss = (exe_op == OP_XLATE) && !xlate_hit;

    // hit index, or the fail bit alone
    always_comb begin
        exe_probe_index = 32'd0;
        if (s1_found) begin
            exe_probe_index[`MMU_IDX_W-1:0] = s1_index;
        end else begin
            exe_probe_index[`MMU_PROBE_FAIL_BIT] = 1'b1;
        end
    end

    assign exe_r_entry = r_entry;

    // only a translation can miss, and a miss carries no address
    a_miss_xlate: assert property (@(posedge clk) disable iff (reset)
        exe_valid && exe_miss |-> (exe_op == OP_XLATE) && (exe_data == 32'd0));

endmodule

// ==== logic/cp0_tlb_result.sv ====
`timescale 1ns/1ps
`include "mmu_consts.svh"

module cp0_tlb_result
    import mmu_op_pkg::*;
    import tlb_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  exe_valid,
    input  mmu_op_e               exe_op,
    input  cp0_sel_e              exe_sel,
    input  logic [31:0]           exe_data,
    input  logic                  exe_miss,
    input  logic                  exe_illegal,
    input  logic [31:0]           exe_probe_index,
    input  tlb_entry_t            exe_r_entry,
    output logic [31:0]           cp0_index,
    output logic [31:0]           cp0_entryhi,
    output logic [31:0]           cp0_entrylo0,
    output logic [31:0]           cp0_entrylo1,
    output logic                  tlb_we,
    output logic [`MMU_IDX_W-1:0] w_index,
    output tlb_entry_t            w_entry,
    output logic                  rsp_valid,
    output logic [31:0]           rsp_data,
    output logic                  rsp_miss,
    output logic                  rsp_illegal
);

    function automatic logic [31:0] lo_pack(tlb_lo_t lo, logic g);
        return {6'd0, lo.pfn, lo.c, lo.d, lo.v, g};
    endfunction

    function automatic tlb_lo_t lo_unpack(logic [31:0] lo);
        tlb_lo_t f;
        f.pfn = lo[`MMU_LO_PFN_MSB:`MMU_LO_PFN_LSB];
        f.c   = lo[`MMU_LO_C_MSB:`MMU_LO_C_LSB];
        f.d   = lo[`MMU_LO_D_BIT];
        f.v   = lo[`MMU_LO_V_BIT];
        return f;
    endfunction

    // write port sees the live registers
    assign tlb_we  = exe_valid && (exe_op == OP_TLBWI);
    assign w_index = cp0_index[`MMU_IDX_W-1:0];

    always_comb begin
        w_entry.vpn2 = cp0_entryhi[`MMU_HI_VPN2_MSB:`MMU_HI_VPN2_LSB];
        w_entry.asid = cp0_entryhi[`MMU_HI_ASID_MSB:`MMU_HI_ASID_LSB];
        // global only if both halves say so
        w_entry.g    = cp0_entrylo0[`MMU_LO_G_BIT] & cp0_entrylo1[`MMU_LO_G_BIT];
        w_entry.lo0  = lo_unpack(cp0_entrylo0);
        w_entry.lo1  = lo_unpack(cp0_entrylo1);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cp0_index    <= 32'd0;
            cp0_entryhi  <= 32'd0;
            cp0_entrylo0 <= 32'd0;
            cp0_entrylo1 <= 32'd0;
        end else if (exe_valid) begin
            case (exe_op)
                OP_MTC0: begin
                    case (exe_sel)
                        SEL_INDEX:    cp0_index    <= 32'(exe_data[`MMU_IDX_W-1:0]);
                        SEL_ENTRYHI:  cp0_entryhi  <= exe_data & `MMU_ENTRYHI_MASK;
                        SEL_ENTRYLO0: cp0_entrylo0 <= exe_data & `MMU_ENTRYLO_MASK;
                        default:      cp0_entrylo1 <= exe_data & `MMU_ENTRYLO_MASK;
                    endcase
                end
                OP_TLBP: cp0_index <= exe_probe_index;
                OP_TLBR: begin
                    cp0_entryhi  <= {exe_r_entry.vpn2, 5'd0, exe_r_entry.asid};
                    cp0_entrylo0 <= lo_pack(exe_r_entry.lo0, exe_r_entry.g);
                    cp0_entrylo1 <= lo_pack(exe_r_entry.lo1, exe_r_entry.g);
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid   <= 1'b0;
            rsp_miss    <= 1'b0;
            rsp_illegal <= 1'b0;
        end else begin
            rsp_valid   <= exe_valid;
            rsp_miss    <= exe_valid && exe_miss;
            rsp_illegal <= exe_valid && exe_illegal;
        end
    end

    always_ff @(posedge clk) begin
        if ((exe_op == OP_MFC0) || (exe_op == OP_XLATE)) begin
            rsp_data <= exe_data;
        end else begin
            rsp_data <= 32'd0;
        end
    end

    // a tlb write answers with one clean response and zero data
    a_we_tlbwi: assert property (@(posedge clk) disable iff (reset)
        tlb_we |=> rsp_valid && !rsp_miss && !rsp_illegal && (rsp_data == 32'd0));

endmodule

// ==== logic/tlb_array.sv ====
`timescale 1ns/1ps
`include "mmu_consts.svh"

module tlb_array
    import tlb_pkg::*;
(
    input  logic                  clk,
    input  logic [31:0]           s0_vaddr,
    input  logic [7:0]            s0_asid,
    input  logic [18:0]           s1_vpn2,
    input  logic [7:0]            s1_asid,
    input  logic                  we,
    input  logic [`MMU_IDX_W-1:0] w_index,
    input  tlb_entry_t            w_entry,
    input  logic [`MMU_IDX_W-1:0] r_index,
    output logic                  s0_found,
    output logic [19:0]           s0_pfn,
    output logic                  s0_v,
    output logic                  s1_found,
    output logic [`MMU_IDX_W-1:0] s1_index,
    output tlb_entry_t            r_entry
);

    tlb_entry_t entry [`MMU_TLBNUM];

    logic [`MMU_IDX_W-1:0] s0_index;
    tlb_lo_t               s0_lo;

    always_ff @(posedge clk) begin
        if (we) begin
            entry[w_index] <= w_entry;
        end
    end

    // returns {found, index}; scanning down leaves the lowest match
    function automatic logic [`MMU_IDX_W:0] lookup(logic [18:0] vpn2, logic [7:0] asid);
        logic [`MMU_IDX_W:0] res;
        res = '0;
        for (int i = `MMU_TLBNUM - 1; i >= 0; i--) begin
            if ((entry[i].vpn2 == vpn2) && (entry[i].g || (entry[i].asid == asid))) begin
                res = {1'b1, i[`MMU_IDX_W-1:0]};
            end
        end
        return res;
    endfunction

    // port 0, translation
    always_comb begin
        {s0_found, s0_index} = lookup(s0_vaddr[31:13], s0_asid);
    end

    // odd page takes the second half
    assign s0_lo  = s0_vaddr[`MMU_ODD_PAGE_BIT] ? entry[s0_index].lo1 : entry[s0_index].lo0;
    assign s0_pfn = s0_lo.pfn;
    assign s0_v   = s0_lo.v;

    // port 1, probe
    always_comb begin
        {s1_found, s1_index} = lookup(s1_vpn2, s1_asid);
    end

    assign r_entry = entry[r_index];

    a_w_index: assert property (@(posedge clk) we |-> (w_index < `MMU_TLBNUM));

endmodule

// ==== logic/mmu_unit_top.sv ====
`timescale 1ns/1ps
`include "mmu_consts.svh"

module mmu_unit_top
    import mmu_op_pkg::*;
    import tlb_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        cmd_valid,
    input  logic [3:0]  cmd_op,
    input  logic [1:0]  cmd_sel,
    input  logic [31:0] cmd_data,
    output logic        rsp_valid,
    output logic [31:0] rsp_data,
    output logic        rsp_miss,
    output logic        rsp_illegal
);

    logic        dec_valid;
    mmu_op_e     dec_op;
    cp0_sel_e    dec_sel;
    logic [31:0] dec_data;
    logic        dec_illegal;

    logic        exe_valid;
    mmu_op_e     exe_op;
    cp0_sel_e    exe_sel;
    logic [31:0] exe_data;
    logic        exe_miss;
    logic        exe_illegal;
    logic [31:0] exe_probe_index;
    tlb_entry_t  exe_r_entry;

    logic [31:0] cp0_index;
    logic [31:0] cp0_entryhi;
    logic [31:0] cp0_entrylo0;
    logic [31:0] cp0_entrylo1;

    logic [31:0]           s0_vaddr;
    logic                  s0_found;
    logic [19:0]           s0_pfn;
    logic                  s0_v;
    logic                  s1_found;
    logic [`MMU_IDX_W-1:0] s1_index;
    tlb_entry_t            r_entry;
    logic                  tlb_we;
    logic [`MMU_IDX_W-1:0] w_index;
    tlb_entry_t            w_entry;

    mmu_cmd_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_sel     (cmd_sel),
        .cmd_data    (cmd_data),
        .dec_valid   (dec_valid),
        .dec_op      (dec_op),
        .dec_sel     (dec_sel),
        .dec_data    (dec_data),
        .dec_illegal (dec_illegal)
    );

    mmu_cmd_execute u_execute (
        .clk             (clk),
        .reset           (reset),
        .dec_valid       (dec_valid),
        .dec_op          (dec_op),
        .dec_sel         (dec_sel),
        .dec_data        (dec_data),
        .dec_illegal     (dec_illegal),
        .cp0_index       (cp0_index),
        .cp0_entryhi     (cp0_entryhi),
        .cp0_entrylo0    (cp0_entrylo0),
        .cp0_entrylo1    (cp0_entrylo1),
        .s0_found        (s0_found),
        .s0_pfn          (s0_pfn),
        .s0_v            (s0_v),
        .s1_found        (s1_found),
        .s1_index        (s1_index),
        .r_entry         (r_entry),
        .s0_vaddr        (s0_vaddr),
        .exe_valid       (exe_valid),
        .exe_op          (exe_op),
        .exe_sel         (exe_sel),
        .exe_data        (exe_data),
        .exe_miss        (exe_miss),
        .exe_illegal     (exe_illegal),
        .exe_probe_index (exe_probe_index),
        .exe_r_entry     (exe_r_entry)
    );

    cp0_tlb_result u_result (
        .clk             (clk),
        .reset           (reset),
        .exe_valid       (exe_valid),
        .exe_op          (exe_op),
        .exe_sel         (exe_sel),
        .exe_data        (exe_data),
        .exe_miss        (exe_miss),
        .exe_illegal     (exe_illegal),
        .exe_probe_index (exe_probe_index),
        .exe_r_entry     (exe_r_entry),
        .cp0_index       (cp0_index),
        .cp0_entryhi     (cp0_entryhi),
        .cp0_entrylo0    (cp0_entrylo0),
        .cp0_entrylo1    (cp0_entrylo1),
        .tlb_we          (tlb_we),
        .w_index         (w_index),
        .w_entry         (w_entry),
        .rsp_valid       (rsp_valid),
        .rsp_data        (rsp_data),
        .rsp_miss        (rsp_miss),
        .rsp_illegal     (rsp_illegal)
    );

    // both search ports use the current asid
    tlb_array u_tlb (
        .clk      (clk),
        .s0_vaddr (s0_vaddr),
        .s0_asid  (cp0_entryhi[`MMU_HI_ASID_MSB:`MMU_HI_ASID_LSB]),
        .s1_vpn2  (cp0_entryhi[`MMU_HI_VPN2_MSB:`MMU_HI_VPN2_LSB]),
        .s1_asid  (cp0_entryhi[`MMU_HI_ASID_MSB:`MMU_HI_ASID_LSB]),
        .we       (tlb_we),
        .w_index  (w_index),
        .w_entry  (w_entry),
        .r_index  (cp0_index[`MMU_IDX_W-1:0]),
        .s0_found (s0_found),
        .s0_pfn   (s0_pfn),
        .s0_v     (s0_v),
        .s1_found (s1_found),
        .s1_index (s1_index),
        .r_entry  (r_entry)
    );

endmodule

// ==== bench/tb_mmu_unit.sv ====
`timescale 1ns/1ps
`include "mmu_consts.svh"

module tb_mmu_unit;

    // raw command codes and register selects
    localparam logic [3:0] RAW_MTC0  = 4'd0;
    localparam logic [3:0] RAW_MFC0  = 4'd1;
    localparam logic [3:0] RAW_TLBP  = 4'd2;
    localparam logic [3:0] RAW_TLBR  = 4'd3;
    localparam logic [3:0] RAW_TLBWI = 4'd4;
    localparam logic [3:0] RAW_XLATE = 4'd5;
    localparam logic [1:0] R_INDEX   = 2'd0;
    localparam logic [1:0] R_HI      = 2'd1;
    localparam logic [1:0] R_LO0     = 2'd2;
    localparam logic [1:0] R_LO1     = 2'd3;

    localparam int RESET_CYCLES = 10;
    localparam int CP0_ITER     = 40;
    localparam int RW_ITER      = 20;
    localparam int PROBE_ITER   = 40;
    localparam int XLATE_ITER   = 60;
    localparam int MIXED_ITER   = 100;
    localparam int N_TESTS      = 5;
    localparam int N_CMDS       = (8 + 2 * CP0_ITER) + (5 * `MMU_TLBNUM + 10 * RW_ITER)
                                + 3 * PROBE_ITER + 2 * XLATE_ITER + (MIXED_ITER + 4);
    // idle slot plus pipeline drain after each test
    localparam int DRAIN_SLACK  = 6;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + N_CMDS + N_TESTS * DRAIN_SLACK + 50;

    logic        clk;
    logic        reset;
    logic        cmd_valid;
    logic [3:0]  cmd_op;
    logic [1:0]  cmd_sel;
    logic [31:0] cmd_data;
    logic        rsp_valid;
    logic [31:0] rsp_data;
    logic        rsp_miss;
    logic        rsp_illegal;

    integer seed = 32308;
    int     cycle = 0;
    int     errors;
    int     checks;
    int     errors_base;

    // reference state
    logic [31:0] m_index;
    logic [31:0] m_entryhi;
    logic [31:0] m_lo0;
    logic [31:0] m_lo1;
    logic [18:0] t_vpn2 [`MMU_TLBNUM];
    logic [7:0]  t_asid [`MMU_TLBNUM];
    logic        t_g    [`MMU_TLBNUM];
    logic [31:0] t_lo0  [`MMU_TLBNUM];
    logic [31:0] t_lo1  [`MMU_TLBNUM];

    // expected responses in issue order
    logic [31:0] exp_data_q    [$];
    logic        exp_miss_q    [$];
    logic        exp_illegal_q [$];
    int          exp_cycle_q   [$];

    mmu_unit_top u_mmu_unit_top (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_sel     (cmd_sel),
        .cmd_data    (cmd_data),
        .rsp_valid   (rsp_valid),
        .rsp_data    (rsp_data),
        .rsp_miss    (rsp_miss),
        .rsp_illegal (rsp_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("ERR %s: got %h, expected %h", name, actual, expected);
            errors++;
        end
    endtask

    // small vpn2 and asid sets so that lookups hit
    function automatic logic [18:0] pick_vpn2();
        logic [31:0] r;
        r = $random(seed);
        return 19'h1_2340 + 19'(r[2:0]);
    endfunction

    function automatic logic [7:0] pick_asid();
        logic [31:0] r;
        r = $random(seed);
        return 8'h10 + 8'(r[1:0]);
    endfunction

    function automatic logic [31:0] rand_entryhi();
        logic [31:0] r;
        r = $random(seed);
        // bits 12:8 random to exercise the write mask
        return {pick_vpn2(), r[4:0], pick_asid()};
    endfunction

    function automatic logic [31:0] rand_vaddr();
        logic [31:0] r;
        r = $random(seed);
        return {pick_vpn2(), r[12:0]};
    endfunction

    // lowest matching index, or -1
    function automatic int find_entry(input logic [18:0] vpn2, input logic [7:0] asid);
        int hit;
        hit = -1;
        for (int i = 0; i < `MMU_TLBNUM; i++) begin
            if ((hit < 0) && (t_vpn2[i] == vpn2) && (t_g[i] || (t_asid[i] == asid))) begin
                hit = i;
            end
        end
        return hit;
    endfunction

    task automatic run_model(input logic [3:0] op, input logic [1:0] sel,
                             input logic [31:0] data, output logic [31:0] d,
                             output logic m, output logic il);
        int          hit;
        int          idx;
        logic [31:0] lo;
        d  = 32'd0;
        m  = 1'b0;
        il = 1'b0;
        idx = m_index[`MMU_IDX_W-1:0];
        case (op)
            RAW_MTC0: begin
                case (sel)
                    R_INDEX: m_index   = {28'd0, data[3:0]};
                    R_HI:    m_entryhi = data & 32'hffff_e0ff;
                    R_LO0:   m_lo0     = data & 32'h03ff_ffff;
                    default: m_lo1     = data & 32'h03ff_ffff;
                endcase
            end
            RAW_MFC0: begin
                case (sel)
                    R_INDEX: d = m_index;
                    R_HI:    d = m_entryhi;
                    R_LO0:   d = m_lo0;
                    default: d = m_lo1;
                endcase
            end
            RAW_TLBP: begin
                hit = find_entry(m_entryhi[31:13], m_entryhi[7:0]);
                m_index = (hit >= 0) ? 32'(hit) : (32'd1 << `MMU_PROBE_FAIL_BIT);
            end
            RAW_TLBR: begin
                m_entryhi = {t_vpn2[idx], 5'd0, t_asid[idx]};
                m_lo0     = t_lo0[idx] | 32'(t_g[idx]);
                m_lo1     = t_lo1[idx] | 32'(t_g[idx]);
            end
            RAW_TLBWI: begin
                t_vpn2[idx] = m_entryhi[31:13];
                t_asid[idx] = m_entryhi[7:0];
                t_g[idx]    = m_lo0[0] & m_lo1[0];
                t_lo0[idx]  = m_lo0 & 32'h03ff_fffe;
                t_lo1[idx]  = m_lo1 & 32'h03ff_fffe;
            end
            RAW_XLATE: begin
                hit = find_entry(data[31:13], m_entryhi[7:0]);
                if (hit < 0) begin
                    m = 1'b1;
                end else begin
                    lo = data[12] ? t_lo1[hit] : t_lo0[hit];
                    if (lo[1]) begin
                        d = {lo[25:6], data[11:0]};
                    end else begin
                        m = 1'b1;
                    end
                end
            end
            default: il = 1'b1;
        endcase
    endtask

    task automatic send_cmd(input logic [3:0] op, input logic [1:0] sel,
                            input logic [31:0] data);
        logic [31:0] d;
        logic        m;
        logic        il;
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        cmd_sel   <= sel;
        cmd_data  <= data;
        run_model(op, sel, data, d, m, il);
        exp_data_q.push_back(d);
        exp_miss_q.push_back(m);
        exp_illegal_q.push_back(il);
        // counter value at the check, three edges past the drive edge
        exp_cycle_q.push_back(cycle + 4);
    endtask

    always @(negedge clk) begin
        if (!reset && rsp_valid) begin
            if (exp_data_q.size() == 0) begin
                $display("response arrived with no command outstanding");
                errors++;
            end else begin
                compare("rsp_data", rsp_data, exp_data_q.pop_front());
                compare("rsp_miss", 32'(rsp_miss), 32'(exp_miss_q.pop_front()));
                compare("rsp_illegal", 32'(rsp_illegal), 32'(exp_illegal_q.pop_front()));
                compare("rsp_cycle", 32'(cycle), 32'(exp_cycle_q.pop_front()));
            end
        end
    end

    task automatic finish_test(input string name);
        @(posedge clk);
        cmd_valid <= 1'b0;
        while (exp_data_q.size() != 0) begin
            @(posedge clk);
        end
        $display("test %s finished: %0d errors", name, errors - errors_base);
        errors_base = errors;
    endtask

    task automatic write_entry(input logic [3:0] idx);
        send_cmd(RAW_MTC0, R_INDEX, {28'd0, idx});
        send_cmd(RAW_MTC0, R_HI, rand_entryhi());
        send_cmd(RAW_MTC0, R_LO0, $random(seed));
        send_cmd(RAW_MTC0, R_LO1, $random(seed));
        send_cmd(RAW_TLBWI, 2'd0, 32'd0);
    endtask

    task automatic read_entry(input logic [3:0] idx);
        send_cmd(RAW_MTC0, R_INDEX, {28'd0, idx});
        send_cmd(RAW_TLBR, 2'd0, 32'd0);
        send_cmd(RAW_MFC0, R_HI, 32'd0);
        send_cmd(RAW_MFC0, R_LO0, 32'd0);
        send_cmd(RAW_MFC0, R_LO1, 32'd0);
    endtask

    task automatic run_cp0_rw();
        logic [31:0] r;
        for (int s = 0; s < 4; s++) begin
            send_cmd(RAW_MTC0, 2'(s), 32'hffff_ffff);
        end
        for (int s = 0; s < 4; s++) begin
            send_cmd(RAW_MFC0, 2'(s), $random(seed));
        end
        for (int i = 0; i < CP0_ITER; i++) begin
            r = $random(seed);
            send_cmd(RAW_MTC0, r[1:0], $random(seed));
            send_cmd(RAW_MFC0, r[1:0], 32'd0);
        end
    endtask

    task automatic run_tlb_rw();
        logic [31:0] r;
        for (int i = 0; i < `MMU_TLBNUM; i++) begin
            write_entry(4'(i));
        end
        for (int i = 0; i < RW_ITER; i++) begin
            r = $random(seed);
            write_entry(r[3:0]);
            read_entry(r[3:0]);
        end
    endtask

    task automatic run_probe();
        for (int i = 0; i < PROBE_ITER; i++) begin
            send_cmd(RAW_MTC0, R_HI, rand_entryhi());
            send_cmd(RAW_TLBP, 2'd0, 32'd0);
            send_cmd(RAW_MFC0, R_INDEX, 32'd0);
        end
    endtask

    task automatic run_xlate();
        for (int i = 0; i < XLATE_ITER; i++) begin
            send_cmd(RAW_MTC0, R_HI, rand_entryhi());
            send_cmd(RAW_XLATE, 2'd0, rand_vaddr());
        end
    endtask

    // every cycle a command, about a quarter of them illegal
    task automatic run_mixed();
        logic [31:0] r;
        logic [3:0]  op;
        logic [1:0]  sel;
        logic [31:0] data;
        for (int i = 0; i < MIXED_ITER; i++) begin
            r = $random(seed);
            if (r[1:0] == 2'd0) begin
                op = 4'd6 + 4'(r[5:2] % 4'd10);
            end else begin
                op = 4'(r[10:8] % 3'd6);
            end
            sel = r[13:12];
            if (op == RAW_XLATE) begin
                data = rand_vaddr();
            end else if ((op == RAW_MTC0) && (sel == R_HI)) begin
                data = rand_entryhi();
            end else begin
                data = $random(seed);
            end
            send_cmd(op, sel, data);
        end
        for (int s = 0; s < 4; s++) begin
            send_cmd(RAW_MFC0, 2'(s), 32'd0);
        end
    endtask

    initial begin
        reset       = 1'b1;
        cmd_valid   = 1'b0;
        cmd_op      = 4'd0;
        cmd_sel     = 2'd0;
        cmd_data    = 32'd0;
        errors      = 0;
        checks      = 0;
        errors_base = 0;
        m_index     = 32'd0;
        m_entryhi   = 32'd0;
        m_lo0       = 32'd0;
        m_lo1       = 32'd0;
        for (int i = 0; i < `MMU_TLBNUM; i++) begin
            t_vpn2[i] = 19'd0;
            t_asid[i] = 8'd0;
            t_g[i]    = 1'b0;
            t_lo0[i]  = 32'd0;
            t_lo1[i]  = 32'd0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        run_cp0_rw();
        finish_test("cp0_rw");
        run_tlb_rw();
        finish_test("tlb_rw");
        run_probe();
        finish_test("probe");
        run_xlate();
        finish_test("xlate");
        run_mixed();
        finish_test("mixed");

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
logic/mmu_op_pkg.sv
logic/tlb_pkg.sv
logic/mmu_cmd_decode.sv
logic/mmu_cmd_execute.sv
logic/cp0_tlb_result.sv
logic/tlb_array.sv
logic/mmu_unit_top.sv
bench/tb_mmu_unit.sv

// ==== Bender.yml ====
package:
  name: mmu_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/mmu_op_pkg.sv
      - logic/tlb_pkg.sv
      - logic/mmu_cmd_decode.sv
      - logic/mmu_cmd_execute.sv
      - logic/cp0_tlb_result.sv
      - logic/tlb_array.sv
      - logic/mmu_unit_top.sv
      - target: test
        files:
          - bench/tb_mmu_unit.sv
